// ==== all.f ====
src/eeprom_pkg.sv
src/eeprom_cmd_decode.sv
src/i2c_byte_engine.sv
src/eeprom_result.sv
src/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_checker.sv
tb/eeprom_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the EEPROM controller testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module eeprom_ctrl_tb \
    -o sim_eeprom_ctrl > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_eeprom_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

// ==== src/eeprom_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_cmd_decode (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0]  req_addr,
    input  logic [7:0]                     req_wdata,
    output logic                           op_valid,
    input  logic                           op_ready,
    output eeprom_pkg::op_kind_t           op_kind,
    output logic [7:0]                     op_byte,
    input  logic                           txn_done
);

    logic                          wr_q;
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [7:0]                    wdata_q;
    logic [2:0]                    step;
    logic [2:0]                    last_step;
    eeprom_pkg::ctrl_byte_t        ctrl;

    assign last_step = wr_q ? 3'd4 : 3'd6;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            req_ready <= 1'b1;
            op_valid  <= 1'b0;
            step      <= 3'd0;
        end
        else if (req_valid && req_ready)
        begin
            req_ready <= 1'b0;
            op_valid  <= 1'b1;
            step      <= 3'd0;
        end
        else if (op_valid && op_ready)
        begin
            if (step == last_step)
                op_valid <= 1'b0;  // sequence sent, wait for the response
            else
                step <= step + 3'd1;
        end
        else if (txn_done && !op_valid)
            req_ready <= 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            wr_q    <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    // write: S ctrl addr data P
    // read:  S ctrl addr S ctrl+r rd P
    always_comb
    begin
        ctrl.f.dev   = eeprom_pkg::DEVICE_CODE;
        ctrl.f.block = addr_q[eeprom_pkg::ADDR_W-1 -: 3];
        ctrl.f.rd    = !wr_q && (step == 3'd4);
        op_byte      = ctrl.raw;
        case (step)
            3'd0: op_kind = eeprom_pkg::OP_START;
            3'd1: op_kind = eeprom_pkg::OP_WRITE;
            3'd2:
            begin
                op_kind = eeprom_pkg::OP_WRITE;
                op_byte = addr_q[7:0];
            end
            3'd3:
            begin
                op_kind = wr_q ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_START;
                op_byte = wdata_q;  // ignored for the repeated start
            end
            3'd4: op_kind = wr_q ? eeprom_pkg::OP_STOP : eeprom_pkg::OP_WRITE;
            3'd5: op_kind = eeprom_pkg::OP_READ;
            default: op_kind = eeprom_pkg::OP_STOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 2
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_write,
    input  logic [eeprom_pkg::ADDR_W-1:0] req_addr,
    input  logic [7:0]                    req_wdata,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic [7:0]                    rsp_rdata,
    output logic                          rsp_nack,
    output logic                          scl,
    output logic                          sda_oe,   // 1 pulls sda low
    input  logic                          sda_in
);

    logic                 op_valid;
    logic                 op_ready;
    eeprom_pkg::op_kind_t op_kind;
    logic [7:0]           op_byte;
    logic                 byte_done;
    logic                 byte_nack;
    logic                 rd_done;
    logic [7:0]           rd_byte;
    logic                 stop_done;
    logic                 txn_done;

    eeprom_cmd_decode i_decode (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_kind   (op_kind),
        .op_byte   (op_byte),
        .txn_done  (txn_done)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) i_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_kind   (op_kind),
        .op_byte   (op_byte),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in),
        .byte_done (byte_done),
        .byte_nack (byte_nack),
        .rd_done   (rd_done),
        .rd_byte   (rd_byte),
        .stop_done (stop_done)
    );

    eeprom_result i_result (
        .CLK       (CLK),
        .RESET     (RESET),
        .byte_done (byte_done),
        .byte_nack (byte_nack),
        .rd_done   (rd_done),
        .rd_byte   (rd_byte),
        .stop_done (stop_done),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .txn_done  (txn_done)
    );

endmodule

`default_nettype wire

// ==== src/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // bus operations handed from the decoder to the byte engine
    typedef enum logic [1:0] {
        OP_START = 2'd0,  // start or repeated start
        OP_WRITE = 2'd1,  // byte out, ack in
        OP_READ  = 2'd2,  // byte in, nack out
        OP_STOP  = 2'd3
    } op_kind_t;

    // control byte fields, msb first on the wire
    typedef struct packed {
        logic [3:0] dev;    // device type code
        logic [2:0] block;  // upper address bits
        logic       rd;     // 1 = read
    } ctrl_fields_t;

    // built by field, shifted as a raw byte
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t f;
    } ctrl_byte_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // 2 KB part
    localparam int ADDR_W = 11;

endpackage

`default_nettype wire

// ==== src/eeprom_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_result (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       byte_done,
    input  logic       byte_nack,
    input  logic       rd_done,
    input  logic [7:0] rd_byte,
    input  logic       stop_done,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output logic [7:0] rsp_rdata,
    output logic       rsp_nack,
    output logic       txn_done
);

    logic       nack_acc;
    logic [7:0] rdata_acc;

    assign txn_done  = rsp_valid && rsp_ready;
    assign rsp_rdata = rdata_acc;  // stays 0 on writes
    assign rsp_nack  = nack_acc;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rsp_valid <= 1'b0;
            nack_acc  <= 1'b0;
            rdata_acc <= 8'h00;
        end
        else if (txn_done)
        begin
            rsp_valid <= 1'b0;
            nack_acc  <= 1'b0;
            rdata_acc <= 8'h00;
        end
        else
        begin
            if (byte_done && byte_nack)
                nack_acc <= 1'b1;
            if (rd_done)
                rdata_acc <= rd_byte;
            if (stop_done)
                rsp_valid <= 1'b1;  // end of transaction
        end
    end

endmodule

`default_nettype wire

// ==== src/i2c_byte_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine #(
    parameter int CLK_DIV = 2  // CLK cycles per quarter scl period
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 op_valid,
    output logic                 op_ready,
    input  eeprom_pkg::op_kind_t op_kind,
    input  logic [7:0]           op_byte,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in,
    output logic                 byte_done,
    output logic                 byte_nack,
    output logic                 rd_done,
    output logic [7:0]           rd_byte,
    output logic                 stop_done
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic                 busy;
    logic                 op_end;     // one cycle after the last quarter
    eeprom_pkg::op_kind_t kind_q;
    logic [DIV_W-1:0]     div_cnt;
    logic                 tick;
    logic [1:0]           q;          // quarter within the scl period
    logic [3:0]           bit_cnt;    // 8 = ack/nack slot
    logic [3:0]           last_bit;
    logic [7:0]           shreg;
    logic                 ack_q;
    logic                 scl_nx;
    logic                 oe_nx;

    assign op_ready = !busy;
    assign tick     = busy && !op_end && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_bit = (kind_q == eeprom_pkg::OP_START || kind_q == eeprom_pkg::OP_STOP)
                      ? 4'd0 : 4'd8;

    assign byte_done = op_end && (kind_q == eeprom_pkg::OP_WRITE);
    assign rd_done   = op_end && (kind_q == eeprom_pkg::OP_READ);
    assign stop_done = op_end && (kind_q == eeprom_pkg::OP_STOP);
    assign byte_nack = ack_q;  // high level = no ack
    assign rd_byte   = shreg;

    // line levels for the current quarter
    always_comb
    begin
        scl_nx = (q == 2'd1) || (q == 2'd2);
        oe_nx  = 1'b0;
        case (kind_q)
            eeprom_pkg::OP_START: oe_nx = q[1];  // sda falls in q2 with scl high
            eeprom_pkg::OP_STOP:
            begin
                scl_nx = (q != 2'd0);
                oe_nx  = !q[1];  // sda released in q2 with scl high
            end
            eeprom_pkg::OP_WRITE: oe_nx = (bit_cnt != 4'd8) && !shreg[7];
            default: oe_nx = 1'b0;  // read bits and nack leave sda to the device
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_end  <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            div_cnt <= '0;
            q       <= 2'd0;
            bit_cnt <= 4'd0;
        end
        else
        begin
            op_end <= 1'b0;
            if (!busy)
            begin
                if (op_valid)
                begin
                    busy    <= 1'b1;
                    div_cnt <= '0;
                    q       <= 2'd0;
                    bit_cnt <= 4'd0;
                end
            end
            else if (op_end)
                busy <= 1'b0;
            else
            begin
                scl    <= scl_nx;
                sda_oe <= oe_nx;
                if (tick)
                begin
                    div_cnt <= '0;
                    q       <= q + 2'd1;
                    if (q == 2'd3)
                    begin
                        if (bit_cnt == last_bit)
                            op_end <= 1'b1;
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                else
                    div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    // payload, no reset
    always_ff @(posedge CLK)
    begin
        if (!busy && op_valid)
        begin
            kind_q <= op_kind;
            shreg  <= op_byte;
        end
        else if (tick)
        begin
            if (q == 2'd2)  // scl high, sample point
            begin
                if (kind_q == eeprom_pkg::OP_READ && bit_cnt != 4'd8)
                    shreg <= {shreg[6:0], sda_in};
                if (kind_q == eeprom_pkg::OP_WRITE && bit_cnt == 4'd8)
                    ack_q <= sda_in;
            end
            if (q == 2'd3 && kind_q == eeprom_pkg::OP_WRITE && bit_cnt != 4'd8)
                shreg <= {shreg[6:0], 1'b0};  // next bit to msb
        end
    end

endmodule

`default_nettype wire

// ==== tb/eeprom_ctrl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_checker (
    input logic       CLK,
    input logic       RESET,
    input logic       req_ready,
    input logic       rsp_valid,
    input logic       rsp_ready,
    input logic [7:0] rsp_rdata,
    input logic       rsp_nack,
    input logic       scl,
    input logic       sda_oe
);

    // response holds under back-pressure
    rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack))
        else $error("response changed while waiting for rsp_ready");

    no_req_with_rsp: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    bus_idle_after_reset: assert property (@(posedge CLK)
        $fell(RESET) |-> scl && !sda_oe)
        else $error("bus not released after reset");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_checker i_checker (
    .CLK       (CLK),
    .RESET     (RESET),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .scl       (scl),
    .sda_oe    (sda_oe)
);

`default_nettype wire

// ==== tb/eeprom_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_tb;

    localparam int TIMEOUT = 2000;  // cycles per wait

    logic                          CLK;
    logic                          RESET;
    logic                          req_valid;
    logic                          req_ready;
    logic                          req_write;
    logic [eeprom_pkg::ADDR_W-1:0] req_addr;
    logic [7:0]                    req_wdata;
    logic                          rsp_valid;
    logic                          rsp_ready;
    logic [7:0]                    rsp_rdata;
    logic                          rsp_nack;
    logic                          scl;
    logic                          sda_oe;
    logic                          sda_in;
    logic                          ack_enable;

    int                            err_count;
    int                            issued;
    int                            responded;
    int                            hold_max;
    int                            seed;
    bit                            aborted;
    logic [7:0]                    shadow [0:2047];
    bit                            written [0:2047];
    logic [7:0]                    exp_rdata_q [$];
    logic                          exp_nack_q [$];
    logic [eeprom_pkg::ADDR_W-1:0] addr_list [$];

    eeprom_ctrl_top #(
        .CLK_DIV (2)
    ) i_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    eeprom_model i_model (
        .CLK        (CLK),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .ack_enable (ack_enable),
        .sda_in     (sda_in)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // last acknowledged write, else erased state
    function automatic logic [7:0] expected_read(input logic [eeprom_pkg::ADDR_W-1:0] addr);
        return written[addr] ? shadow[addr] : 8'hFF;
    endfunction

    task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Fail rsp_rdata: got %h, expected %h", got, exp);
            err_count++;
        end
    endtask

    task automatic check_nack(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail rsp_nack: got %h, expected %h", got, exp);
            err_count++;
        end
    endtask

    task automatic issue_req(input logic wr,
                             input logic [eeprom_pkg::ADDR_W-1:0] addr,
                             input logic [7:0] data);
        int n;
        if (aborted)
            return;
        @(negedge CLK);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        n = 0;
        while (!req_ready && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!req_ready)
        begin
            $display("Timeout: the controller never accepted the request");
            err_count++;
            aborted   = 1'b1;
            req_valid = 1'b0;
            return;
        end
        if (issued != responded)
        begin
            $display("A request was accepted while a response was still pending");
            err_count++;
        end
        // handshake on the coming rising edge
        if (wr)
            exp_rdata_q.push_back(8'h00);
        else
            exp_rdata_q.push_back(ack_enable ? expected_read(addr) : 8'hFF);
        exp_nack_q.push_back(!ack_enable);
        if (wr && ack_enable)
        begin
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end
        issued++;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (issued != responded && !aborted && n < 4 * TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (issued != responded && !aborted)
        begin
            $display("Timeout: outstanding responses never arrived");
            err_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic collect_response();
        int         n;
        int         hold;
        logic [7:0] exp_rdata;
        logic       exp_nack;
        n = 0;
        while (!rsp_valid && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!rsp_valid)
        begin
            $display("Timeout: no response from the controller");
            err_count++;
            aborted = 1'b1;
            return;
        end
        exp_rdata = exp_rdata_q.pop_front();
        exp_nack  = exp_nack_q.pop_front();
        check_rdata(rsp_rdata, exp_rdata);
        check_nack(rsp_nack, exp_nack);
        hold = $unsigned($random(seed)) % (hold_max + 1);
        repeat (hold)
        begin
            @(negedge CLK);
            if (!rsp_valid)
            begin
                $display("rsp_valid dropped before the handshake");
                err_count++;
            end
            check_rdata(rsp_rdata, exp_rdata);  // held under back-pressure
            check_nack(rsp_nack, exp_nack);
            if (req_ready)
            begin
                $display("req_ready went high while the response was held");
                err_count++;
            end
        end
        rsp_ready = 1'b1;  // handshake on the coming rising edge
        responded++;
        @(negedge CLK);
        rsp_ready = 1'b0;
    endtask

    // compare process
    initial
    begin
        forever
        begin
            @(negedge CLK);
            if (!aborted && issued > responded)
                collect_response();
        end
    end

    initial
    begin
        logic [31:0]                   r;
        logic [eeprom_pkg::ADDR_W-1:0] a;
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_ready  = 1'b0;
        ack_enable = 1'b1;
        err_count  = 0;
        issued     = 0;
        responded  = 0;
        hold_max   = 2;
        aborted    = 1'b0;
        seed       = 82481;
        for (int i = 0; i < 2048; i++)
            written[i] = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        issue_req(1'b1, 11'h123, 8'h5A);  // write then read back
        issue_req(1'b0, 11'h123, 8'h00);
        issue_req(1'b0, 11'h7FE, 8'h00);  // never written

        // random mix, block bits cycle through all values
        for (int i = 0; i < 40; i++)
        begin
            r = $random(seed);
            a = {i[3:1], r[7:0]};
            if (i % 2 == 0)
            begin
                issue_req(1'b1, a, r[15:8]);
                addr_list.push_back(a);
            end
            else if (r[17:16] != 2'b00)
                issue_req(1'b0, addr_list[r[31:20] % addr_list.size()], 8'h00);
            else
                issue_req(1'b0, a, 8'h00);
        end

        // long back-pressure with requests queued behind
        wait_idle();
        hold_max = 20;
        for (int i = 0; i < 6; i++)
        begin
            r = $random(seed);
            if (i % 2 == 0)
                issue_req(1'b1, r[10:0], r[23:16]);
            else
                issue_req(1'b0, r[10:0], 8'h00);
        end
        wait_idle();
        hold_max = 2;

        // device absent
        @(negedge CLK);
        ack_enable = 1'b0;
        issue_req(1'b1, 11'h123, 8'hA5);
        issue_req(1'b0, 11'h123, 8'h00);
        issue_req(1'b1, 11'h456, 8'h3C);
        wait_idle();
        @(negedge CLK);
        ack_enable = 1'b1;
        issue_req(1'b0, 11'h123, 8'h00);  // still the old byte
        issue_req(1'b0, 11'h456, 8'h00);
        wait_idle();

        repeat (5) @(negedge CLK);
        $display("error count: %0d", err_count);
        if (err_count == 0 && !aborted)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda_oe,
    input  logic ack_enable,
    output logic sda_in
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_DATA,
        S_TX
    } model_state_t;

    logic [7:0]   mem [0:2047];
    model_state_t state;
    logic         scl_d;
    logic         sda_d;
    logic         sda;
    logic         pull;     // device pulls sda low
    logic [3:0]   cnt;      // rising scl edges in this byte
    logic [7:0]   shift;
    logic [7:0]   tx_byte;
    logic [2:0]   blk;
    logic         rd_mode;
    logic [10:0]  ptr;

    // wired-AND of both open-drain drivers
    assign sda    = !sda_oe && !pull;
    assign sda_in = sda;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        state   = S_IDLE;
        scl_d   = 1'b1;
        sda_d   = 1'b1;
        pull    = 1'b0;
        cnt     = 4'd0;
        shift   = 8'h00;
        tx_byte = 8'hFF;
        blk     = 3'd0;
        rd_mode = 1'b0;
        ptr     = 11'd0;
    end

    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (scl && scl_d && sda_d && !sda)
        begin
            state <= S_CTRL;  // start or repeated start
            cnt   <= 4'd0;
            pull  <= 1'b0;
        end
        else if (scl && scl_d && !sda_d && sda)
        begin
            state <= S_IDLE;  // stop
            pull  <= 1'b0;
        end
        else if (state != S_IDLE)
        begin
            if (!scl_d && scl)
            begin
                if (cnt < 4'd8)
                    shift <= {shift[6:0], sda};
                cnt <= cnt + 4'd1;
            end
            else if (scl_d && !scl)
            begin
                if (state == S_TX)
                begin
                    if (cnt == 4'd9)
                    begin
                        state <= S_IDLE;  // master nack seen
                        pull  <= 1'b0;
                    end
                    else if (cnt == 4'd8)
                        pull <= 1'b0;
                    else
                        pull <= !tx_byte[7 - cnt];
                end
                else if (cnt == 4'd8)
                begin
                    // ack slot begins
                    if (!ack_enable)
                        state <= S_IDLE;
                    else
                    begin
                        case (state)
                            S_CTRL:
                            begin
                                if (shift[7:4] == eeprom_pkg::DEVICE_CODE)
                                begin
                                    pull    <= 1'b1;
                                    rd_mode <= shift[0];
                                    if (!shift[0])
                                        blk <= shift[3:1];
                                    tx_byte <= mem[ptr];
                                end
                                else
                                    state <= S_IDLE;
                            end
                            S_ADDR:
                            begin
                                pull <= 1'b1;
                                ptr  <= {blk, shift};
                            end
                            default:
                            begin
                                pull     <= 1'b1;
                                mem[ptr] <= shift;  // no write-cycle delay
                            end
                        endcase
                    end
                end
                else if (cnt == 4'd9)
                begin
                    cnt <= 4'd0;
                    case (state)
                        S_CTRL:
                        begin
                            state <= rd_mode ? S_TX : S_ADDR;
                            pull  <= rd_mode ? !tx_byte[7] : 1'b0;
                        end
                        S_ADDR:
                        begin
                            state <= S_DATA;
                            pull  <= 1'b0;
                        end
                        default:
                        begin
                            state <= S_IDLE;
                            pull  <= 1'b0;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire
